// File: common/fb_writer_pkg.sv
// Shared widths, burst constants and state encodings for the framebuffer writer
package fb_writer_pkg;

    // Bus widths
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int FB_SIZE_LG = 20;

    // Command word layout, opcode on top and byte size at the bottom
    localparam int OP_WIDTH = 2;
    localparam int SIZE_WIDTH = FB_SIZE_LG + 1;
    localparam int CMD_PAD_WIDTH = ADDR_WIDTH - OP_WIDTH - SIZE_WIDTH;

    // Beat and burst geometry
    localparam int BYTES_PER_BEAT = 4;
    localparam int BEAT_SHIFT = $clog2(BYTES_PER_BEAT);
    localparam int RND_WIDTH = SIZE_WIDTH + 1;
    localparam int BEAT_WIDTH = RND_WIDTH - BEAT_SHIFT;
    localparam int MAX_BURST_BEATS = 16;
    localparam int BURST_BYTES = MAX_BURST_BEATS * BYTES_PER_BEAT;
    localparam int LEN_WIDTH = 8;

    // Response tracking
    localparam int BRESP_WIDTH = 2;
    localparam logic [BRESP_WIDTH-1:0] BRESP_OKAY = 2'b00;
    localparam int OUT_WIDTH = 4;
    localparam int OUT_MAX = 15;

    typedef enum logic [OP_WIDTH-1:0] {
        OP_NONE  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } dma_op_e;

    typedef enum logic [1:0] {
        CM_IDLE,
        CM_ADDR,
        CM_FLUSH
    } commit_state_e;

    typedef enum logic [1:0] {
        DS_CMD,
        DS_ADDR,
        DS_BURST,
        DS_DRAIN
    } dma_state_e;

endpackage

// File: dma_write/dma_aw_gen.sv
// AXI write address generator with a per-burst address counter
`timescale 1ns/1ps

module dma_aw_gen (
    input  logic                                aclk,
    input  logic                                resetn,
    input  logic                                aw_load,
    input  logic [fb_writer_pkg::ADDR_WIDTH-1:0] aw_base,
    input  logic                                burst_start,
    input  logic [fb_writer_pkg::LEN_WIDTH-1:0] burst_len,
    output logic                                aw_sent,
    output logic [fb_writer_pkg::ADDR_WIDTH-1:0] mem_awaddr,
    output logic [fb_writer_pkg::LEN_WIDTH-1:0] mem_awlen,
    output logic                                mem_awvalid,
    input  logic                                mem_awready
);

    assign aw_sent = mem_awvalid && mem_awready;

    // Address counter stepping by one full 64-byte burst
    always_ff @(posedge aclk)
    begin
        if (aw_load)
            mem_awaddr <= aw_base;
        else if (aw_sent)
            mem_awaddr <= mem_awaddr + (fb_writer_pkg::ADDR_WIDTH)'(fb_writer_pkg::BURST_BYTES);
    end

    // AXI length field counts beats minus one
    always_ff @(posedge aclk)
    begin
        if (burst_start)
            mem_awlen <= burst_len - 1'b1;
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
            mem_awvalid <= 1'b0;
        else if (burst_start)
            mem_awvalid <= 1'b1;
        else if (aw_sent)
            mem_awvalid <= 1'b0;
    end

    // No new burst or base reaches the generator while an address is still offered
    a_no_reload: assert property (@(posedge aclk) disable iff (!resetn)
        (burst_start || aw_load) |-> !mem_awvalid);

endmodule

// File: dma_write/dma_w_beat_path.sv
// Write data path that forwards the display stream onto the AXI W channel
`timescale 1ns/1ps

module dma_w_beat_path (
    input  logic                                 aclk,
    input  logic                                 resetn,
    input  logic                                 burst_start,
    input  logic [fb_writer_pkg::LEN_WIDTH-1:0]  burst_len,
    output logic                                 w_burst_done,
    input  logic                                 disp_tvalid,
    output logic                                 disp_tready,
    input  logic                                 disp_tlast,
    input  logic [fb_writer_pkg::DATA_WIDTH-1:0] disp_tdata,
    output logic [fb_writer_pkg::DATA_WIDTH-1:0] mem_wdata,
    output logic [fb_writer_pkg::STRB_WIDTH-1:0] mem_wstrb,
    output logic                                 mem_wlast,
    output logic                                 mem_wvalid,
    input  logic                                 mem_wready
);

    logic w_active;
    logic [fb_writer_pkg::LEN_WIDTH-1:0] beats_rem;
    logic w_take;

    // Straight pass-through while a burst is open
    assign mem_wvalid = w_active && disp_tvalid;
    assign disp_tready = w_active && mem_wready;
    assign mem_wdata = disp_tdata;
    assign mem_wstrb = '1;
    assign mem_wlast = (beats_rem == (fb_writer_pkg::LEN_WIDTH)'(1));

    assign w_take = mem_wvalid && mem_wready;
    assign w_burst_done = w_take && mem_wlast;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            w_active <= 1'b0;
            beats_rem <= '0;
        end
        else if (burst_start)
        begin
            w_active <= 1'b1;
            beats_rem <= burst_len;
        end
        else if (w_take)
        begin
            beats_rem <= beats_rem - 1'b1;
            if (mem_wlast)
                w_active <= 1'b0;
        end
    end

    // Frame end only on a burst end, and no further burst follows right after it
    a_tlast_on_final: assert property (@(posedge aclk) disable iff (!resetn)
        disp_tvalid && disp_tready && disp_tlast |-> mem_wlast ##1 !burst_start);

endmodule

// File: dma_write/dma_write_ctrl.sv
// DMA write control that decodes commands, sequences bursts and tracks write responses
`timescale 1ns/1ps

module dma_write_ctrl (
    input  logic                                  aclk,
    input  logic                                  resetn,
    input  logic                                  cmd_valid,
    output logic                                  cmd_ready,
    input  logic [fb_writer_pkg::ADDR_WIDTH-1:0]  cmd_data,
    input  logic                                  cmd_last,
    output logic                                  aw_load,
    output logic [fb_writer_pkg::ADDR_WIDTH-1:0]  aw_base,
    output logic                                  burst_start,
    output logic [fb_writer_pkg::LEN_WIDTH-1:0]   burst_len,
    input  logic                                  aw_sent,
    input  logic                                  w_burst_done,
    input  logic [fb_writer_pkg::BRESP_WIDTH-1:0] mem_bresp,
    input  logic                                  mem_bvalid,
    output logic                                  mem_bready,
    output logic                                  dma_error
);

    fb_writer_pkg::dma_state_e state;
    logic do_store;
    logic [fb_writer_pkg::BEAT_WIDTH-1:0] beats_left;
    logic [fb_writer_pkg::OUT_WIDTH-1:0] outstanding;
    logic w_busy;
    logic aw_pending;
    logic cmd_take;
    logic op_take;
    logic b_take;
    logic store_op;
    logic [fb_writer_pkg::RND_WIDTH-1:0] bytes_rounded;
    logic [fb_writer_pkg::BEAT_WIDTH-1:0] cmd_beats;

    assign cmd_ready = (state == fb_writer_pkg::DS_CMD) || (state == fb_writer_pkg::DS_ADDR);
    assign cmd_take = cmd_valid && cmd_ready;
    // A word flagged last in DS_CMD is a stray address word and is dropped
    assign op_take = cmd_take && (state == fb_writer_pkg::DS_CMD) && !cmd_last;
    // Responses are always sunk and counted against the issued bursts
    assign mem_bready = 1'b1;
    assign b_take = mem_bvalid && mem_bready;

    // Opcode word decode
    assign store_op = fb_writer_pkg::dma_op_e'(
        cmd_data[fb_writer_pkg::ADDR_WIDTH-1 -: fb_writer_pkg::OP_WIDTH]) == fb_writer_pkg::OP_STORE;
    // Round partial words up to a full beat
    assign bytes_rounded = {1'b0, cmd_data[fb_writer_pkg::SIZE_WIDTH-1:0]}
                         + (fb_writer_pkg::RND_WIDTH)'(fb_writer_pkg::BYTES_PER_BEAT - 1);
    assign cmd_beats = bytes_rounded[fb_writer_pkg::RND_WIDTH-1:fb_writer_pkg::BEAT_SHIFT];

    assign aw_load = cmd_take && (state == fb_writer_pkg::DS_ADDR) && do_store;
    assign aw_base = cmd_data;

    assign burst_len = (beats_left >= fb_writer_pkg::MAX_BURST_BEATS)
                     ? (fb_writer_pkg::LEN_WIDTH)'(fb_writer_pkg::MAX_BURST_BEATS)
                     : (fb_writer_pkg::LEN_WIDTH)'(beats_left);
    // One burst in the data path at a time, and its address must be gone first
    assign burst_start = (state == fb_writer_pkg::DS_BURST) && (beats_left != '0)
                       && !w_busy && !aw_pending
                       && (outstanding != (fb_writer_pkg::OUT_WIDTH)'(fb_writer_pkg::OUT_MAX));

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= fb_writer_pkg::DS_CMD;
            do_store <= 1'b0;
            dma_error <= 1'b0;
        end
        else
        begin
            case (state)
                fb_writer_pkg::DS_CMD:
                begin
                    if (op_take)
                    begin
                        do_store <= store_op && (cmd_beats != '0);
                        if (store_op)
                            dma_error <= 1'b0;
                        state <= fb_writer_pkg::DS_ADDR;
                    end
                end
                fb_writer_pkg::DS_ADDR:
                begin
                    if (cmd_take)
                        state <= do_store ? fb_writer_pkg::DS_BURST : fb_writer_pkg::DS_CMD;
                end
                fb_writer_pkg::DS_BURST:
                begin
                    if ((beats_left == '0) && !w_busy && !aw_pending)
                        state <= fb_writer_pkg::DS_DRAIN;
                end
                fb_writer_pkg::DS_DRAIN:
                begin
                    if (outstanding == '0)
                        state <= fb_writer_pkg::DS_CMD;
                end
                default:
                begin
                    state <= fb_writer_pkg::DS_CMD;
                end
            endcase
            // Sticky until the next store command
            if (b_take && (mem_bresp != fb_writer_pkg::BRESP_OKAY))
                dma_error <= 1'b1;
        end
    end

    // Beat budget, burst bookkeeping and outstanding responses
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            beats_left <= '0;
            w_busy <= 1'b0;
            aw_pending <= 1'b0;
            outstanding <= '0;
        end
        else
        begin
            if (op_take)
                beats_left <= store_op ? cmd_beats : '0;
            else if (burst_start)
                beats_left <= beats_left - (fb_writer_pkg::BEAT_WIDTH)'(burst_len);

            if (burst_start)
                w_busy <= 1'b1;
            else if (w_burst_done)
                w_busy <= 1'b0;

            if (burst_start)
                aw_pending <= 1'b1;
            else if (aw_sent)
                aw_pending <= 1'b0;

            case ({burst_start, b_take})
                2'b10: outstanding <= outstanding + 1'b1;
                2'b01: outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Memory never answers more bursts than were issued
    a_no_underflow: assert property (@(posedge aclk) disable iff (!resetn)
        b_take |-> outstanding != '0);

endmodule

// File: flist.f
common/fb_writer_pkg.sv
hdl/fb_commit_ctrl.sv
dma_write/dma_write_ctrl.sv
dma_write/dma_aw_gen.sv
dma_write/dma_w_beat_path.sv
hdl/display_fb_writer.sv
verification/tb_axi_mem_model.sv
verification/tb_display_fb_writer.sv

// File: hdl/display_fb_writer.sv
// Display framebuffer writer top joining the commit front end and the DMA write engine
`timescale 1ns/1ps

module display_fb_writer (
    input  logic                                  aclk,
    input  logic                                  resetn,

    input  logic                                  commit_fb,
    input  logic [fb_writer_pkg::ADDR_WIDTH-1:0]  fb_addr,
    input  logic [fb_writer_pkg::FB_SIZE_LG-1:0]  fb_size,
    output logic                                  fb_committed,

    // Display stream
    input  logic                                  disp_tvalid,
    output logic                                  disp_tready,
    input  logic                                  disp_tlast,
    input  logic [fb_writer_pkg::DATA_WIDTH-1:0]  disp_tdata,

    // Memory write channels
    output logic [fb_writer_pkg::ADDR_WIDTH-1:0]  mem_awaddr,
    output logic [fb_writer_pkg::LEN_WIDTH-1:0]   mem_awlen,
    output logic                                  mem_awvalid,
    input  logic                                  mem_awready,
    output logic [fb_writer_pkg::DATA_WIDTH-1:0]  mem_wdata,
    output logic [fb_writer_pkg::STRB_WIDTH-1:0]  mem_wstrb,
    output logic                                  mem_wlast,
    output logic                                  mem_wvalid,
    input  logic                                  mem_wready,
    input  logic [fb_writer_pkg::BRESP_WIDTH-1:0] mem_bresp,
    input  logic                                  mem_bvalid,
    output logic                                  mem_bready,

    output logic                                  dma_error
);

    // Command stream
    logic cmd_valid;
    logic cmd_ready;
    logic [fb_writer_pkg::ADDR_WIDTH-1:0] cmd_data;
    logic cmd_last;

    // Burst control
    logic aw_load;
    logic [fb_writer_pkg::ADDR_WIDTH-1:0] aw_base;
    logic burst_start;
    logic [fb_writer_pkg::LEN_WIDTH-1:0] burst_len;
    logic aw_sent;
    logic w_burst_done;

    fb_commit_ctrl fb_commit_ctrl_i (
        .aclk         (aclk),
        .resetn       (resetn),
        .commit_fb    (commit_fb),
        .fb_addr      (fb_addr),
        .fb_size      (fb_size),
        .fb_committed (fb_committed),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_data     (cmd_data),
        .cmd_last     (cmd_last)
    );

    dma_write_ctrl dma_write_ctrl_i (
        .aclk         (aclk),
        .resetn       (resetn),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_data     (cmd_data),
        .cmd_last     (cmd_last),
        .aw_load      (aw_load),
        .aw_base      (aw_base),
        .burst_start  (burst_start),
        .burst_len    (burst_len),
        .aw_sent      (aw_sent),
        .w_burst_done (w_burst_done),
        .mem_bresp    (mem_bresp),
        .mem_bvalid   (mem_bvalid),
        .mem_bready   (mem_bready),
        .dma_error    (dma_error)
    );

    dma_aw_gen dma_aw_gen_i (
        .aclk         (aclk),
        .resetn       (resetn),
        .aw_load      (aw_load),
        .aw_base      (aw_base),
        .burst_start  (burst_start),
        .burst_len    (burst_len),
        .aw_sent      (aw_sent),
        .mem_awaddr   (mem_awaddr),
        .mem_awlen    (mem_awlen),
        .mem_awvalid  (mem_awvalid),
        .mem_awready  (mem_awready)
    );

    dma_w_beat_path dma_w_beat_path_i (
        .aclk         (aclk),
        .resetn       (resetn),
        .burst_start  (burst_start),
        .burst_len    (burst_len),
        .w_burst_done (w_burst_done),
        .disp_tvalid  (disp_tvalid),
        .disp_tready  (disp_tready),
        .disp_tlast   (disp_tlast),
        .disp_tdata   (disp_tdata),
        .mem_wdata    (mem_wdata),
        .mem_wstrb    (mem_wstrb),
        .mem_wlast    (mem_wlast),
        .mem_wvalid   (mem_wvalid),
        .mem_wready   (mem_wready)
    );

endmodule

// File: hdl/fb_commit_ctrl.sv
// Commit front end that turns a frame commit into opcode and address command words
`timescale 1ns/1ps

module fb_commit_ctrl (
    input  logic                                 aclk,
    input  logic                                 resetn,
    input  logic                                 commit_fb,
    input  logic [fb_writer_pkg::ADDR_WIDTH-1:0] fb_addr,
    input  logic [fb_writer_pkg::FB_SIZE_LG-1:0] fb_size,
    output logic                                 fb_committed,
    output logic                                 cmd_valid,
    input  logic                                 cmd_ready,
    output logic [fb_writer_pkg::ADDR_WIDTH-1:0] cmd_data,
    output logic                                 cmd_last
);

    fb_writer_pkg::commit_state_e state;

    // Control sequence
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= fb_writer_pkg::CM_IDLE;
            fb_committed <= 1'b1;
            cmd_valid <= 1'b0;
            cmd_last <= 1'b0;
        end
        else
        begin
            case (state)
                fb_writer_pkg::CM_IDLE:
                begin
                    if (commit_fb)
                    begin
                        cmd_valid <= 1'b1;
                        cmd_last <= 1'b0;
                        fb_committed <= 1'b0;
                        state <= fb_writer_pkg::CM_ADDR;
                    end
                end
                fb_writer_pkg::CM_ADDR:
                begin
                    if (cmd_ready)
                    begin
                        cmd_last <= 1'b1;
                        state <= fb_writer_pkg::CM_FLUSH;
                    end
                end
                fb_writer_pkg::CM_FLUSH:
                begin
                    // Early acknowledge, the frame data is still to be written
                    if (cmd_ready)
                    begin
                        cmd_valid <= 1'b0;
                        cmd_last <= 1'b0;
                        fb_committed <= 1'b1;
                        state <= fb_writer_pkg::CM_IDLE;
                    end
                end
                default:
                begin
                    state <= fb_writer_pkg::CM_IDLE;
                end
            endcase
        end
    end

    // Command payload, size doubled since fb_size counts 16-bit pixels
    always_ff @(posedge aclk)
    begin
        if ((state == fb_writer_pkg::CM_IDLE) && commit_fb)
            cmd_data <= {fb_writer_pkg::OP_STORE, {fb_writer_pkg::CMD_PAD_WIDTH{1'b0}},
                         fb_size, 1'b0};
        else if ((state == fb_writer_pkg::CM_ADDR) && cmd_ready)
            cmd_data <= fb_addr;
    end

    // A stalled command word keeps its payload until accepted
    a_cmd_stable: assert property (@(posedge aclk) disable iff (!resetn)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data));

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the framebuffer writer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
    --top-module tb_display_fb_writer --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// File: verification/tb_axi_mem_model.sv
// Behavioral AXI write slave with random ready stalls, word storage and error injection
`timescale 1ns/1ps

module tb_axi_mem_model (
    input  logic        aclk,
    input  logic        resetn,
    input  logic [31:0] awaddr,
    input  logic [7:0]  awlen,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic        stalls,
    input  int          err_burst
);

    logic [31:0] mem [int];
    logic [31:0] aw_q [$];
    int len_q [$];
    // Every accepted burst, in arrival order
    logic [31:0] log_addr [$];
    int log_len [$];
    int beat_idx;
    int b_pending;
    int b_issued;
    int beats_total;
    int protocol_errors;
    logic [31:0] rng;
    logic [31:0] waddr;
    logic aw_fire;
    logic w_fire;
    logic b_fire;

    // Roughly one stall in four when stalls are enabled
    function automatic logic stall_draw();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return stalls && (rng[1:0] == 2'b00);
    endfunction

    initial
    begin
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = 2'b00;
        rng = 32'hc72a2d3c;
        beat_idx = 0;
        b_pending = 0;
        b_issued = 0;
        beats_total = 0;
        protocol_errors = 0;
        forever
        begin
            @(posedge aclk);
            aw_fire = awvalid && awready;
            w_fire = wvalid && wready;
            b_fire = bvalid && bready;
            if (!resetn)
            begin
                aw_q.delete();
                len_q.delete();
                beat_idx = 0;
                b_pending = 0;
            end
            else
            begin
                // W is only accepted once its burst address is known
                if (w_fire)
                begin
                    waddr = (aw_q[0] >> 2) + 32'(beat_idx);
                    mem[int'(waddr)] = wdata;
                    beat_idx++;
                    beats_total++;
                    if (wstrb != 4'hf)
                        protocol_errors++;
                    if (wlast != (beat_idx == len_q[0] + 1))
                        protocol_errors++;
                    if (beat_idx == len_q[0] + 1)
                    begin
                        void'(aw_q.pop_front());
                        void'(len_q.pop_front());
                        beat_idx = 0;
                        b_pending++;
                    end
                end
                if (aw_fire)
                begin
                    aw_q.push_back(awaddr);
                    len_q.push_back(int'(awlen));
                    log_addr.push_back(awaddr);
                    log_len.push_back(int'(awlen));
                end
                if (b_fire)
                    b_issued++;
            end
            #1;
            if (b_fire)
                bvalid = 1'b0;
            if (!resetn)
            begin
                awready = 1'b0;
                wready = 1'b0;
                bvalid = 1'b0;
            end
            else
            begin
                awready = !stall_draw();
                wready = (aw_q.size() != 0) && !stall_draw();
                if (!bvalid && (b_pending > 0))
                begin
                    bvalid = 1'b1;
                    bresp = (b_issued == err_burst) ? 2'b10 : 2'b00;
                    b_pending--;
                end
            end
        end
    end

endmodule

// File: verification/tb_display_fb_writer.sv
// Testbench for the display framebuffer writer with random frames and an AXI memory model
`timescale 1ns/1ps

module tb_display_fb_writer;

    logic aclk = 1'b0;
    logic resetn;
    logic commit_fb;
    logic [31:0] fb_addr;
    logic [19:0] fb_size;
    logic fb_committed;
    logic disp_tvalid;
    logic disp_tready;
    logic disp_tlast;
    logic [31:0] disp_tdata;
    logic [31:0] mem_awaddr;
    logic [7:0] mem_awlen;
    logic mem_awvalid;
    logic mem_awready;
    logic [31:0] mem_wdata;
    logic [3:0] mem_wstrb;
    logic mem_wlast;
    logic mem_wvalid;
    logic mem_wready;
    logic [1:0] mem_bresp;
    logic mem_bvalid;
    logic mem_bready;
    logic dma_error;
    logic stalls;
    int err_burst;

    logic [31:0] rng = 32'hc72a2d3c;
    int errors = 0;
    int test_start = 0;
    bit commit_pending = 1'b0;
    logic [31:0] next_base;
    int px;
    int f;

    always #5 aclk = ~aclk;

    display_fb_writer display_fb_writer_i (.*);

    tb_axi_mem_model mem_model_i (
        .aclk(aclk), .resetn(resetn),
        .awaddr(mem_awaddr), .awlen(mem_awlen), .awvalid(mem_awvalid), .awready(mem_awready),
        .wdata(mem_wdata), .wstrb(mem_wstrb), .wlast(mem_wlast), .wvalid(mem_wvalid),
        .wready(mem_wready), .bresp(mem_bresp), .bvalid(mem_bvalid), .bready(mem_bready),
        .stalls(stalls), .err_burst(err_burst)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic report_test(input int n, input string name);
        $display("test %0d %s: %s", n, name, (errors == test_start) ? "pass" : "FAIL");
        test_start = errors;
    endtask

    // Runs one frame through commit, streaming and responses, then compares with the model
    task automatic do_frame(input logic [31:0] base, input int pixels, input bit hold,
                            input bit gaps);
        int words;
        int nbursts;
        int burst0;
        int beats0;
        int b0;
        int i;
        int k;
        int cnt;
        int gap;
        int rem;
        bit fire;
        logic [31:0] exp [$];
        words = (pixels + 1) / 2;
        nbursts = (words + 15) / 16;
        burst0 = mem_model_i.log_addr.size();
        beats0 = mem_model_i.beats_total;
        b0 = mem_model_i.b_issued;
        for (i = 0; i < words; i++)
            exp.push_back(rand_word());
        if (!commit_pending)
        begin
            @(posedge aclk);
            #1;
            commit_fb = 1'b1;
            fb_addr = base;
            fb_size = 20'(pixels);
            // First word is already offered while the commit is in flight
            disp_tvalid = 1'b1;
            disp_tdata = exp[0];
            disp_tlast = (words == 1);
            @(posedge aclk);
            #1;
            if (!hold)
                commit_fb = 1'b0;
            cnt = 0;
            while (fb_committed && (cnt < 50))
            begin
                @(negedge aclk);
                cnt++;
            end
            if (fb_committed)
                report_timeout("fb_committed never fell after commit_fb");
            cnt = 0;
            while (!fb_committed && (cnt < 200))
            begin
                @(negedge aclk);
                cnt++;
            end
            if (!fb_committed)
                report_timeout("fb_committed never returned high");
            else
                check("W beats before fb_committed", 32'(mem_model_i.beats_total - beats0), 0);
            // Address of the follow-up command is sampled later
            if (hold)
                fb_addr = next_base;
        end
        commit_pending = 1'b0;
        @(posedge aclk);
        #1;
        for (i = 0; i < words; i++)
        begin
            if (gaps && (i != 0))
            begin
                disp_tvalid = 1'b0;
                gap = int'(rand_word() % 3);
                repeat (gap)
                begin
                    @(posedge aclk);
                    #1;
                end
            end
            disp_tvalid = 1'b1;
            disp_tdata = exp[i];
            disp_tlast = (i == words - 1);
            fire = 1'b0;
            cnt = 0;
            while (!fire && (cnt < 2000))
            begin
                @(posedge aclk);
                fire = disp_tready;
                cnt++;
            end
            #1;
            if (!fire)
            begin
                report_timeout("display stream word was never accepted");
                i = words;
            end
        end
        disp_tvalid = 1'b0;
        disp_tlast = 1'b0;
        cnt = 0;
        while ((mem_model_i.b_issued < b0 + nbursts) && (cnt < 5000))
        begin
            @(negedge aclk);
            cnt++;
        end
        if (mem_model_i.b_issued < b0 + nbursts)
            report_timeout("write responses did not all arrive");
        check("burst count", 32'(mem_model_i.log_addr.size() - burst0), 32'(nbursts));
        for (k = 0; (k < nbursts) && (burst0 + k < mem_model_i.log_addr.size()); k++)
        begin
            rem = words - 16 * k;
            check("mem_awaddr", mem_model_i.log_addr[burst0 + k], base + 32'(64 * k));
            check("mem_awlen", 32'(mem_model_i.log_len[burst0 + k]),
                  32'(((rem > 16) ? 16 : rem) - 1));
        end
        for (i = 0; i < words; i++)
            check("memory word", mem_model_i.mem[int'((base >> 2) + 32'(i))], exp[i]);
        check("wlast and wstrb errors", 32'(mem_model_i.protocol_errors), 0);
        if (hold)
        begin
            commit_pending = 1'b1;
            @(posedge aclk);
            #1;
            commit_fb = 1'b0;
        end
    endtask

    initial
    begin
        resetn = 1'b0;
        commit_fb = 1'b0;
        fb_addr = '0;
        fb_size = '0;
        disp_tvalid = 1'b0;
        disp_tlast = 1'b0;
        disp_tdata = '0;
        stalls = 1'b0;
        err_burst = -1;
        repeat (4) @(posedge aclk);
        #1;
        resetn = 1'b1;

        check("fb_committed", 32'(fb_committed), 1);
        check("mem_awvalid", 32'(mem_awvalid), 0);
        check("mem_wvalid", 32'(mem_wvalid), 0);
        check("disp_tready", 32'(disp_tready), 0);
        report_test(1, "reset state");

        do_frame(rand_word() & 32'h00ff_ffc0, 1 + int'(rand_word() % 600), 1'b0, 1'b0);
        report_test(2, "single frame");

        // Held commit_fb queues a second command behind the first transfer
        px = 1 + int'(rand_word() % 600);
        next_base = rand_word() & 32'h00ff_ffc0;
        do_frame(rand_word() & 32'h00ff_ffc0, px, 1'b1, 1'b0);
        do_frame(next_base, px, 1'b0, 1'b0);
        report_test(3, "early acknowledge");

        stalls = 1'b1;
        do_frame(rand_word() & 32'h00ff_ffc0, 1 + int'(rand_word() % 600), 1'b0, 1'b1);
        report_test(4, "back-pressure");

        err_burst = mem_model_i.b_issued;
        do_frame(rand_word() & 32'h00ff_ffc0, 1 + int'(rand_word() % 600), 1'b0, 1'b1);
        check("dma_error", 32'(dma_error), 1);
        err_burst = -1;
        do_frame(rand_word() & 32'h00ff_ffc0, 1 + int'(rand_word() % 600), 1'b0, 1'b1);
        check("dma_error", 32'(dma_error), 0);
        report_test(5, "error flag");

        for (f = 0; f < 4; f++)
        begin
            px = (f == 0) ? 33 : 1 + int'(rand_word() % 600);
            do_frame(rand_word() & 32'h00ff_ffc0, px, 1'b0, 1'b1);
        end
        report_test(6, "back-to-back frames");

        $display("tests done, %0d errors", errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
